/* Bender.yml */
package:
  name: plic

sources:
  - common/plic_pkg.sv
  - plic_gateway/plic_gateway.sv
  - hdl/plic_regs.sv
  - hdl/plic_target.sv
  - hdl/plic_top.sv
  - target: simulation
    files:
      - tb/plic_tb.sv

/* common/plic_pkg.sv */
`default_nettype none

package plic_pkg;

  // Source ids run 1..SRC_COUNT, id 0 means no interrupt
  localparam int SRC_COUNT = 8;
  localparam int TGT_COUNT = 2;
  localparam int SRC_ID_W  = 4;

  // Register port
  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;

  // Address map, per-source and per-target registers sit at base plus index
  localparam logic [ADDR_W-1:0] ADDR_PRIO_BASE   = 8'h00; // Plus source id
  localparam logic [ADDR_W-1:0] ADDR_PENDING     = 8'h10; // Read only
  localparam logic [ADDR_W-1:0] ADDR_EDGE        = 8'h11;
  localparam logic [ADDR_W-1:0] ADDR_ENABLE_BASE = 8'h20; // Plus target
  localparam logic [ADDR_W-1:0] ADDR_THRESH_BASE = 8'h30; // Plus target
  localparam logic [ADDR_W-1:0] ADDR_CLAIM_BASE  = 8'h38; // Plus target

  // Bit i of pending, edge and enable masks belongs to source i+1
  typedef logic [SRC_ID_W-1:0] src_id_t;

  // Claim and complete pulses from the register file to the gateway
  typedef struct packed {
    logic [TGT_COUNT-1:0]    claim_req;
    logic [TGT_COUNT-1:0]    complete_req;
    src_id_t [TGT_COUNT-1:0] complete_idx;
  } regs2gateway_t;

endpackage

`default_nettype wire

/* hdl/plic_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module plic_regs #(
  parameter int PRIO_W = 3
) (
  input  wire                                              clk,
  input  wire                                              rst_n,
  input  wire                                              reg_we_i,
  input  wire                                              reg_re_i,
  input  wire [plic_pkg::ADDR_W-1:0]                       reg_addr_i,
  input  wire [plic_pkg::DATA_W-1:0]                       reg_wdata_i,
  output logic [plic_pkg::DATA_W-1:0]                      reg_rdata_o,
  input  wire [plic_pkg::SRC_COUNT-1:0]                    pending_i,
  input  wire plic_pkg::src_id_t [plic_pkg::TGT_COUNT-1:0] max_id_i,
  output plic_pkg::regs2gateway_t                          regs2gateway_o,
  output plic_pkg::src_id_t [plic_pkg::TGT_COUNT-1:0]      claim_idx_o,
  output logic [plic_pkg::SRC_COUNT-1:0]                   edge_select_o,
  output logic [plic_pkg::SRC_COUNT-1:0][PRIO_W-1:0]       prio_o,
  output logic [plic_pkg::TGT_COUNT-1:0][plic_pkg::SRC_COUNT-1:0] enable_o,
  output logic [plic_pkg::TGT_COUNT-1:0][PRIO_W-1:0]       thresh_o
);

  logic [plic_pkg::SRC_COUNT-1:0][PRIO_W-1:0]              prio_ff;   // Index s is source s+1
  logic [plic_pkg::TGT_COUNT-1:0][plic_pkg::SRC_COUNT-1:0] enable_ff;
  logic [plic_pkg::TGT_COUNT-1:0][PRIO_W-1:0]              thresh_ff;
  logic [plic_pkg::SRC_COUNT-1:0]                          edge_ff;
  logic [plic_pkg::DATA_W-1:0]                             rdata_ff;
  logic [plic_pkg::DATA_W-1:0]                             rdata_next;

  // Configuration writes, source 0 priority and pending are not writable
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prio_ff   <= '0;
      enable_ff <= '0;
      thresh_ff <= '0;
      edge_ff   <= '0;
    end else if (reg_we_i) begin
      for (int s = 0; s < plic_pkg::SRC_COUNT; s++) begin
        if (reg_addr_i == plic_pkg::ADDR_PRIO_BASE + s + 1) begin
          prio_ff[s] <= reg_wdata_i[PRIO_W-1:0];
        end
      end
      if (reg_addr_i == plic_pkg::ADDR_EDGE) begin
        edge_ff <= reg_wdata_i[plic_pkg::SRC_COUNT-1:0];
      end
      for (int t = 0; t < plic_pkg::TGT_COUNT; t++) begin
        if (reg_addr_i == plic_pkg::ADDR_ENABLE_BASE + t) begin
          enable_ff[t] <= reg_wdata_i[plic_pkg::SRC_COUNT-1:0];
        end
        if (reg_addr_i == plic_pkg::ADDR_THRESH_BASE + t) begin
          thresh_ff[t] <= reg_wdata_i[PRIO_W-1:0];
        end
      end
    end
  end

  // Read mux plus claim/complete pulses
  always_comb begin
    rdata_next    = '0;  // Unmapped addresses read zero
    regs2gateway_o = '0;
    for (int s = 0; s < plic_pkg::SRC_COUNT; s++) begin
      if (reg_addr_i == plic_pkg::ADDR_PRIO_BASE + s + 1) begin
        rdata_next[PRIO_W-1:0] = prio_ff[s];
      end
    end
    if (reg_addr_i == plic_pkg::ADDR_PENDING) begin
      rdata_next[plic_pkg::SRC_COUNT-1:0] = pending_i;
    end
    if (reg_addr_i == plic_pkg::ADDR_EDGE) begin
      rdata_next[plic_pkg::SRC_COUNT-1:0] = edge_ff;
    end
    for (int t = 0; t < plic_pkg::TGT_COUNT; t++) begin
      if (reg_addr_i == plic_pkg::ADDR_ENABLE_BASE + t) begin
        rdata_next[plic_pkg::SRC_COUNT-1:0] = enable_ff[t];
      end
      if (reg_addr_i == plic_pkg::ADDR_THRESH_BASE + t) begin
        rdata_next[PRIO_W-1:0] = thresh_ff[t];
      end
      if (reg_addr_i == plic_pkg::ADDR_CLAIM_BASE + t) begin
        rdata_next[plic_pkg::SRC_ID_W-1:0] = max_id_i[t];  // Id seen at the strobe
        regs2gateway_o.claim_req[t]    = reg_re_i;
        regs2gateway_o.complete_req[t] = reg_we_i;
      end
      regs2gateway_o.complete_idx[t] = reg_wdata_i[plic_pkg::SRC_ID_W-1:0];
    end
  end

  // Read data holds until the next strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_ff <= '0;
    end else if (reg_re_i) begin
      rdata_ff <= rdata_next;
    end
  end

  assign reg_rdata_o   = rdata_ff;
  assign claim_idx_o   = max_id_i;
  assign edge_select_o = edge_ff;
  assign prio_o        = prio_ff;
  assign enable_o      = enable_ff;
  assign thresh_o      = thresh_ff;

endmodule

`default_nettype wire

/* hdl/plic_target.sv */
`timescale 1ns/1ps
`default_nettype none

module plic_target #(
  parameter int PRIO_W = 3
) (
  input  wire [plic_pkg::SRC_COUNT-1:0]             pending_i,
  input  wire [plic_pkg::SRC_COUNT-1:0]             enable_i,
  input  wire [plic_pkg::SRC_COUNT-1:0][PRIO_W-1:0] prio_i,
  input  wire [PRIO_W-1:0]                          thresh_i,
  output plic_pkg::src_id_t                         max_id_o,
  output logic                                      irq_o
);

  logic [plic_pkg::SRC_COUNT-1:0] eligible;
  logic [PRIO_W-1:0]              best_prio;
  plic_pkg::src_id_t              best_id;

  assign eligible = pending_i & enable_i;

  // Linear scan from the lowest id, strict compare keeps the lower id on a tie.
  // Starting from the threshold means a winner must be strictly above it.
  always_comb begin
    best_prio = thresh_i;
    best_id   = '0;
    for (int s = 0; s < plic_pkg::SRC_COUNT; s++) begin
      if (eligible[s] && (prio_i[s] > best_prio)) begin
        best_prio = prio_i[s];
        best_id   = plic_pkg::src_id_t'(s + 1);
      end
    end
  end

  assign max_id_o = best_id;
  assign irq_o    = |best_id;  // Any winner raises the line

endmodule

`default_nettype wire

/* hdl/plic_top.sv */
`timescale 1ns/1ps
`default_nettype none

module plic_top #(
  parameter int PRIO_W = 3
) (
  input  wire                               clk,
  input  wire                               rst_n,
  input  wire [plic_pkg::SRC_COUNT-1:0]     irq_src_i,
  input  wire                               reg_we_i,
  input  wire                               reg_re_i,
  input  wire [plic_pkg::ADDR_W-1:0]        reg_addr_i,
  input  wire [plic_pkg::DATA_W-1:0]        reg_wdata_i,
  output wire [plic_pkg::DATA_W-1:0]        reg_rdata_o,
  output wire [plic_pkg::TGT_COUNT-1:0]     irq_o
);

  wire plic_pkg::regs2gateway_t                          regs2gateway;
  wire plic_pkg::src_id_t [plic_pkg::TGT_COUNT-1:0]      claim_idx;
  wire plic_pkg::src_id_t [plic_pkg::TGT_COUNT-1:0]      max_id;   // Best id per target
  wire [plic_pkg::SRC_COUNT-1:0]                         edge_select;
  wire [plic_pkg::SRC_COUNT-1:0]                         irq_pending;
  wire [plic_pkg::SRC_COUNT-1:0][PRIO_W-1:0]             prio;
  wire [plic_pkg::TGT_COUNT-1:0][plic_pkg::SRC_COUNT-1:0] enable;
  wire [plic_pkg::TGT_COUNT-1:0][PRIO_W-1:0]             thresh;

  plic_gateway u_gateway (
    .clk            (clk),
    .rst_n          (rst_n),
    .irq_src_i      (irq_src_i),
    .edge_select_i  (edge_select),
    .regs2gateway_i (regs2gateway),
    .claim_idx_i    (claim_idx),
    .irq_pending_o  (irq_pending)
  );

  plic_regs #(.PRIO_W(PRIO_W)) u_regs (
    .clk            (clk),
    .rst_n          (rst_n),
    .reg_we_i       (reg_we_i),
    .reg_re_i       (reg_re_i),
    .reg_addr_i     (reg_addr_i),
    .reg_wdata_i    (reg_wdata_i),
    .reg_rdata_o    (reg_rdata_o),
    .pending_i      (irq_pending),
    .max_id_i       (max_id),
    .regs2gateway_o (regs2gateway),
    .claim_idx_o    (claim_idx),
    .edge_select_o  (edge_select),
    .prio_o         (prio),
    .enable_o       (enable),
    .thresh_o       (thresh)
  );

  // One selector per target
  for (genvar t = 0; t < plic_pkg::TGT_COUNT; t++) begin : g_target
    plic_target #(.PRIO_W(PRIO_W)) u_target (
      .pending_i (irq_pending),
      .enable_i  (enable[t]),
      .prio_i    (prio),
      .thresh_i  (thresh[t]),
      .max_id_o  (max_id[t]),
      .irq_o     (irq_o[t])
    );
  end

endmodule

`default_nettype wire

/* plic_gateway/plic_gateway.sv */
`timescale 1ns/1ps
`default_nettype none

module plic_gateway (
  input  wire                                            clk,
  input  wire                                            rst_n,
  input  wire [plic_pkg::SRC_COUNT-1:0]                  irq_src_i,
  input  wire [plic_pkg::SRC_COUNT-1:0]                  edge_select_i,  // 1 is edge, 0 is level
  input  wire plic_pkg::regs2gateway_t                   regs2gateway_i,
  input  wire plic_pkg::src_id_t [plic_pkg::TGT_COUNT-1:0] claim_idx_i,
  output logic [plic_pkg::SRC_COUNT-1:0]                 irq_pending_o
);

  logic [plic_pkg::SRC_COUNT-1:0] irq_src_ff;
  logic [plic_pkg::SRC_COUNT-1:0] irq_req;
  logic [plic_pkg::SRC_COUNT-1:0] irq_set;
  logic [plic_pkg::SRC_COUNT-1:0] pending_ff;
  logic [plic_pkg::SRC_COUNT-1:0] active_ff;
  logic [plic_pkg::SRC_COUNT-1:0] claim;     // One-hot per source
  logic [plic_pkg::SRC_COUNT-1:0] complete;  // One-hot per source

  // Previous source level for rising edge detection
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq_src_ff <= '0;
    end else begin
      irq_src_ff <= irq_src_i;
    end
  end

  always_comb begin
    for (int s = 0; s < plic_pkg::SRC_COUNT; s++) begin
      irq_req[s] = edge_select_i[s] ? (irq_src_i[s] & ~irq_src_ff[s]) : irq_src_i[s];
    end
  end

  // Decode the per-target ids into source masks, id 0 never matches
  always_comb begin
    claim    = '0;
    complete = '0;
    for (int t = 0; t < plic_pkg::TGT_COUNT; t++) begin
      for (int s = 0; s < plic_pkg::SRC_COUNT; s++) begin
        if (regs2gateway_i.claim_req[t] &&
            claim_idx_i[t] == plic_pkg::src_id_t'(s + 1)) begin
          claim[s] = 1'b1;
        end
        if (regs2gateway_i.complete_req[t] &&
            regs2gateway_i.complete_idx[t] == plic_pkg::src_id_t'(s + 1)) begin
          complete[s] = 1'b1;
        end
      end
    end
  end

  // A request is only taken while the source is idle
  assign irq_set = irq_req & ~active_ff;

  // Pending lives until the claim, active until the complete
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending_ff <= '0;
      active_ff  <= '0;
    end else begin
      pending_ff <= (pending_ff | irq_set) & ~claim;
      active_ff  <= (active_ff | irq_set) & ~complete;
    end
  end

  assign irq_pending_o = pending_ff;

endmodule

`default_nettype wire

/* src.f */
common/plic_pkg.sv
plic_gateway/plic_gateway.sv
hdl/plic_regs.sv
hdl/plic_target.sv
hdl/plic_top.sv
tb/plic_tb.sv

/* tb/plic_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module plic_tb;

  localparam int PRIO_W          = 3;
  localparam int SRC_COUNT       = plic_pkg::SRC_COUNT;
  localparam int TGT_COUNT       = plic_pkg::TGT_COUNT;
  localparam int SRC_ID_W        = plic_pkg::SRC_ID_W;
  localparam int ADDR_W          = plic_pkg::ADDR_W;
  localparam int DATA_W          = plic_pkg::DATA_W;
  localparam int WATCHDOG_CYCLES = 2000;  // Whole sequence needs a few hundred cycles

  logic                 clk;
  logic                 rst_n;
  logic [SRC_COUNT-1:0] irq_src;
  logic                 reg_we;
  logic                 reg_re;
  logic [ADDR_W-1:0]    reg_addr;
  logic [DATA_W-1:0]    reg_wdata;
  wire  [DATA_W-1:0]    reg_rdata;
  wire  [TGT_COUNT-1:0] irq;
  int                   errors;
  integer               seed;

  // Reference model state
  logic [SRC_COUNT-1:0]                 m_pending;
  logic [SRC_COUNT-1:0]                 m_active;
  logic [SRC_COUNT-1:0]                 m_src_prev;
  logic [SRC_COUNT-1:0]                 m_edge;
  logic [SRC_COUNT-1:0]                 m_req;
  logic [SRC_COUNT-1:0]                 m_claim;
  logic [SRC_COUNT-1:0]                 m_complete;
  logic [SRC_COUNT-1:0][PRIO_W-1:0]     m_prio;
  logic [TGT_COUNT-1:0][SRC_COUNT-1:0]  m_enable;
  logic [TGT_COUNT-1:0][PRIO_W-1:0]     m_thresh;
  logic [TGT_COUNT-1:0][SRC_ID_W-1:0]   exp_id;
  logic [TGT_COUNT-1:0]                 exp_irq;
  logic [DATA_W-1:0]                    exp_rdata;
  logic                                 check_rd;  // A read was strobed last cycle

  plic_top #(.PRIO_W(PRIO_W)) plic_top_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .irq_src_i   (irq_src),
    .reg_we_i    (reg_we),
    .reg_re_i    (reg_re),
    .reg_addr_i  (reg_addr),
    .reg_wdata_i (reg_wdata),
    .reg_rdata_o (reg_rdata),
    .irq_o       (irq)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Highest priority strictly above the threshold with ties to the lower id
  function automatic logic [SRC_ID_W-1:0] pick_source(
    input logic [SRC_COUNT-1:0]             pend,
    input logic [SRC_COUNT-1:0]             en,
    input logic [SRC_COUNT-1:0][PRIO_W-1:0] prio,
    input logic [PRIO_W-1:0]                thresh
  );
    logic [SRC_ID_W-1:0] id;
    logic [PRIO_W-1:0]   top;
    id  = '0;
    top = '0;
    for (int s = SRC_COUNT; s >= 1; s--) begin  // Downward walk where >= gives a tie to the lower id
      if (pend[s-1] && en[s-1] && prio[s-1] > thresh && prio[s-1] >= top) begin
        id  = SRC_ID_W'(s);
        top = prio[s-1];
      end
    end
    return id;
  endfunction

  function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] addr);
    logic [DATA_W-1:0] value;
    value = '0;
    for (int s = 1; s <= SRC_COUNT; s++) begin
      if (addr == ADDR_W'(plic_pkg::ADDR_PRIO_BASE + s)) value[PRIO_W-1:0] = m_prio[s-1];
    end
    if (addr == plic_pkg::ADDR_PENDING) value[SRC_COUNT-1:0] = m_pending;
    if (addr == plic_pkg::ADDR_EDGE) value[SRC_COUNT-1:0] = m_edge;
    for (int t = 0; t < TGT_COUNT; t++) begin
      if (addr == ADDR_W'(plic_pkg::ADDR_ENABLE_BASE + t)) value[SRC_COUNT-1:0] = m_enable[t];
      if (addr == ADDR_W'(plic_pkg::ADDR_THRESH_BASE + t)) value[PRIO_W-1:0] = m_thresh[t];
      if (addr == ADDR_W'(plic_pkg::ADDR_CLAIM_BASE + t)) value[SRC_ID_W-1:0] = exp_id[t];
    end
    return value;
  endfunction

  assign m_req = (m_edge & irq_src & ~m_src_prev) | (~m_edge & irq_src);

  always @* begin
    m_claim    = '0;
    m_complete = '0;
    for (int t = 0; t < TGT_COUNT; t++) begin
      exp_id[t]  = pick_source(m_pending, m_enable[t], m_prio, m_thresh[t]);
      exp_irq[t] = (exp_id[t] != '0);
      for (int s = 0; s < SRC_COUNT; s++) begin
        if (reg_addr == ADDR_W'(plic_pkg::ADDR_CLAIM_BASE + t)) begin
          if (reg_re && exp_id[t] == SRC_ID_W'(s + 1)) m_claim[s] = 1'b1;
          if (reg_we && reg_wdata[SRC_ID_W-1:0] == SRC_ID_W'(s + 1)) m_complete[s] = 1'b1;
        end
      end
    end
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_pending  <= '0;
      m_active   <= '0;
      m_src_prev <= '0;
      m_edge     <= '0;
      m_prio     <= '0;
      m_enable   <= '0;
      m_thresh   <= '0;
      exp_rdata  <= '0;
      check_rd   <= 1'b0;
    end else begin
      m_src_prev <= irq_src;
      m_pending  <= (m_pending | (m_req & ~m_active)) & ~m_claim;  // Requests while active drop
      m_active   <= (m_active | (m_req & ~m_active)) & ~m_complete;
      check_rd   <= reg_re;
      if (reg_re) exp_rdata <= expected_read(reg_addr);
      if (reg_we) begin
        for (int s = 1; s <= SRC_COUNT; s++) begin
          if (reg_addr == ADDR_W'(plic_pkg::ADDR_PRIO_BASE + s)) begin
            m_prio[s-1] <= reg_wdata[PRIO_W-1:0];
          end
        end
        if (reg_addr == plic_pkg::ADDR_EDGE) m_edge <= reg_wdata[SRC_COUNT-1:0];
        for (int t = 0; t < TGT_COUNT; t++) begin
          if (reg_addr == ADDR_W'(plic_pkg::ADDR_ENABLE_BASE + t)) begin
            m_enable[t] <= reg_wdata[SRC_COUNT-1:0];
          end
          if (reg_addr == ADDR_W'(plic_pkg::ADDR_THRESH_BASE + t)) begin
            m_thresh[t] <= reg_wdata[PRIO_W-1:0];
          end
        end
      end
    end
  end

  irq_matches_model: assert property (@(posedge clk) disable iff (!rst_n) irq == exp_irq)
    else begin
      errors++;
      $display("[FAIL] %0t irq_o is %b, expected %b", $time, $sampled(irq), $sampled(exp_irq));
    end

  rdata_matches_model: assert property (@(posedge clk) disable iff (!rst_n)
    check_rd |-> reg_rdata == exp_rdata)
    else begin
      errors++;
      $display("[FAIL] %0t reg_rdata_o is %h, expected %h", $time, $sampled(reg_rdata),
               $sampled(exp_rdata));
    end

  task automatic reg_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    @(negedge clk);
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_we    = 1'b0;
  endtask

  task automatic reg_read(input logic [ADDR_W-1:0] addr);
    @(negedge clk);
    reg_re   = 1'b1;
    reg_addr = addr;
    @(negedge clk);
    reg_re   = 1'b0;
  endtask

  task automatic claim(input int t);
    reg_read(ADDR_W'(plic_pkg::ADDR_CLAIM_BASE + t));
  endtask

  task automatic complete(input int t, input int id);
    reg_write(ADDR_W'(plic_pkg::ADDR_CLAIM_BASE + t), DATA_W'(id));
  endtask

  task automatic pulse_source(input int s);
    @(negedge clk) irq_src[s] = 1'b1;
    @(negedge clk) irq_src[s] = 1'b0;
  endtask

  task automatic expect_irq(input logic [TGT_COUNT-1:0] want);
    @(negedge clk);
    assert (irq == want)
      else begin
        errors++;
        $display("[FAIL] %0t irq_o is %b, expected %b", $time, irq, want);
      end
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the test did not finish", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    errors    = 0;
    seed      = 32'hd940;
    rst_n     = 1'b0;
    irq_src   = '0;
    reg_we    = 1'b0;
    reg_re    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    repeat (16) @(posedge clk);
    @(negedge clk) rst_n = 1'b1;

    // Reset values
    expect_irq(2'b00);
    assert (reg_rdata == '0)
      else begin
        errors++;
        $display("[FAIL] %0t reg_rdata_o is %h after reset", $time, reg_rdata);
      end
    reg_read(plic_pkg::ADDR_PENDING);
    reg_read(plic_pkg::ADDR_EDGE);
    for (int s = 0; s <= SRC_COUNT; s++) reg_read(ADDR_W'(plic_pkg::ADDR_PRIO_BASE + s));
    for (int t = 0; t < TGT_COUNT; t++) begin
      reg_read(ADDR_W'(plic_pkg::ADDR_ENABLE_BASE + t));
      reg_read(ADDR_W'(plic_pkg::ADDR_THRESH_BASE + t));
    end

    // Source 0 priority and the pending register ignore writes
    reg_write(plic_pkg::ADDR_PRIO_BASE, 7);
    reg_write(plic_pkg::ADDR_PENDING, 8'hff);
    reg_read(plic_pkg::ADDR_PRIO_BASE);
    reg_read(ADDR_W'(plic_pkg::ADDR_PRIO_BASE + 1));
    reg_read(plic_pkg::ADDR_PENDING);

    // Level source 3 on target 0
    reg_write(plic_pkg::ADDR_THRESH_BASE, 2);
    reg_write(ADDR_W'(plic_pkg::ADDR_PRIO_BASE + 3), 5);
    reg_write(plic_pkg::ADDR_ENABLE_BASE, 8'h04);
    @(negedge clk) irq_src = 8'h04;
    expect_irq(2'b01);
    claim(0);
    reg_read(plic_pkg::ADDR_PENDING);  // Cleared while active holds
    complete(0, 3);
    reg_read(plic_pkg::ADDR_PENDING);  // Level still high so it pends again
    @(negedge clk) irq_src = '0;
    claim(0);
    complete(0, 3);

    // Random priorities in 1..4 so ties are certain
    reg_write(plic_pkg::ADDR_THRESH_BASE, 0);
    reg_write(plic_pkg::ADDR_ENABLE_BASE, 8'hff);
    for (int s = 1; s <= SRC_COUNT; s++) begin
      reg_write(ADDR_W'(plic_pkg::ADDR_PRIO_BASE + s), 1 + ($random(seed) & 3));
    end
    @(negedge clk) irq_src = 8'hff;
    expect_irq(2'b01);
    repeat (SRC_COUNT + 1) claim(0);  // Last one finds nothing
    @(negedge clk) irq_src = '0;
    for (int s = 1; s <= SRC_COUNT; s++) complete(0, s);

    // Threshold and enable masking across both targets
    reg_write(ADDR_W'(plic_pkg::ADDR_PRIO_BASE + 5), 3);
    reg_write(ADDR_W'(plic_pkg::ADDR_PRIO_BASE + 6), 2);
    reg_write(plic_pkg::ADDR_THRESH_BASE, 3);
    reg_write(ADDR_W'(plic_pkg::ADDR_THRESH_BASE + 1), 1);
    reg_write(plic_pkg::ADDR_ENABLE_BASE, 8'h30);
    reg_write(ADDR_W'(plic_pkg::ADDR_ENABLE_BASE + 1), 8'h30);
    @(negedge clk) irq_src = 8'h30;
    expect_irq(2'b10);
    reg_write(ADDR_W'(plic_pkg::ADDR_PRIO_BASE + 6), 7);
    reg_write(plic_pkg::ADDR_ENABLE_BASE, 8'h10);
    expect_irq(2'b10);
    reg_write(plic_pkg::ADDR_ENABLE_BASE, 8'h20);
    expect_irq(2'b11);
    claim(1);
    claim(1);
    claim(0);
    @(negedge clk) irq_src = '0;
    complete(1, 6);
    complete(1, 5);

    // Edge mode on source 1
    reg_write(plic_pkg::ADDR_EDGE, 8'h01);
    reg_write(ADDR_W'(plic_pkg::ADDR_PRIO_BASE + 1), 4);
    reg_write(plic_pkg::ADDR_THRESH_BASE, 0);
    reg_write(plic_pkg::ADDR_ENABLE_BASE, 8'h01);
    pulse_source(0);
    expect_irq(2'b01);
    claim(0);
    pulse_source(0);  // Dropped while active
    claim(0);
    reg_read(plic_pkg::ADDR_PENDING);
    complete(0, 1);
    @(negedge clk) irq_src[0] = 1'b1;  // Held high, only the rising edge counts
    claim(0);
    complete(0, 1);
    reg_read(plic_pkg::ADDR_PENDING);
    @(negedge clk) irq_src[0] = 1'b0;
    pulse_source(0);
    claim(0);
    complete(0, 1);
    repeat (2) @(negedge clk);

    $display("Test finished with %0d errors", errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
